//--- decode_cfg.svh
// Decode stage sizes
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// Machine word and instruction width
`define DATA_WIDTH 16

// Architectural registers
`define REG_COUNT 8

// Opcode field at the top of the instruction
`define OPCODE_WIDTH 5

`endif

//--- isaPkg.sv
// Instruction set types
`default_nettype none

package isaPkg;

	`include "decode_cfg.svh"

	// Raw fetched instruction
	typedef logic [`DATA_WIDTH-1:0] instrT;

	// Bits 15:11 of the instruction
	typedef logic [`OPCODE_WIDTH-1:0] opcodeT;

	typedef logic [$clog2(`REG_COUNT)-1:0] regIdxT;

	// Data path word, also carries the extended immediate
	typedef logic [`DATA_WIDTH-1:0] wordT;

	// R format function select, bits 1:0
	typedef logic [1:0] funcT;

	// Field layouts
	typedef enum logic [1:0] {
		fmtR,
		fmtI1,
		fmtI2,
		fmtJ
	} formatT;

endpackage

`default_nettype wire

//--- ctlPkg.sv
// Control side types
`default_nettype none

package ctlPkg;

	// Order is fixed, the two R groups follow function select order
	typedef enum logic [4:0] {
		aluAdd,
		aluSub,
		aluXor,
		aluAndn,
		aluRol,
		aluSll,
		aluRor,
		aluSrl,
		aluSeq,
		aluSlt,
		aluSle,
		aluSco,
		aluBtr,
		aluLbi,
		aluSlbi,
		aluEqz,
		aluNez,
		aluLtz,
		aluGez,
		aluPass
	} aluOpT;

	typedef enum logic {
		stRun,
		stHalted
	} decStateT;

endpackage

`default_nettype wire

//--- ctlIf.sv
// Decoded control bundle
`timescale 1ns/1ps
`default_nettype none

interface ctlIf import ctlPkg::*; ();

	logic regWrite;
	logic aluSrc;
	logic memWrite;
	logic memRead;
	logic memToReg;
	logic branch;
	logic jump;
	logic link;
	logic stu;
	aluOpT aluOp;
	logic halt;
	logic noOp;
	logic illegal;

	modport source (
		output regWrite, aluSrc, memWrite, memRead, memToReg, branch, jump,
		output link, stu, aluOp, halt, noOp, illegal
	);

	modport sink (
		input regWrite, aluSrc, memWrite, memRead, memToReg, branch, jump,
		input link, stu, aluOp, halt, noOp, illegal
	);

endinterface

`default_nettype wire

//--- opndIf.sv
// Register indices and immediate
`timescale 1ns/1ps
`default_nettype none

interface opndIf import isaPkg::*; ();

	regIdxT rs;
	regIdxT rt;
	regIdxT rd;
	wordT imm;

	modport source (
		output rs, rt, rd, imm
	);

	modport sink (
		input rs, rt, rd, imm
	);

endinterface

`default_nettype wire

//--- controlDecoder.sv
// Opcode and function decoder
`timescale 1ns/1ps
`default_nettype none

module controlDecoder import isaPkg::*, ctlPkg::*; (
	input instrT instr,
	ctlIf.source ctl
);

	opcodeT op;
	funcT func;

	assign op = instr[15:11];
	assign func = instr[1:0];

	// Arithmetic group when shift is low, rotate and shift group otherwise
	function automatic aluOpT pickOp(input logic shift, input funcT sel);
		aluOpT res;
		case ({shift, sel})
			3'b000: res = aluAdd;
			3'b001: res = aluSub;
			3'b010: res = aluXor;
			3'b011: res = aluAndn;
			3'b100: res = aluRol;
			3'b101: res = aluSll;
			3'b110: res = aluRor;
			default: res = aluSrl;
		endcase
		return res;
	endfunction

	always_comb begin
		ctl.regWrite = 1'b0;
		ctl.aluSrc = 1'b0;
		ctl.memWrite = 1'b0;
		ctl.memRead = 1'b0;
		ctl.memToReg = 1'b0;
		ctl.branch = 1'b0;
		ctl.jump = 1'b0;
		ctl.link = 1'b0;
		ctl.stu = 1'b0;
		ctl.aluOp = aluPass;
		ctl.halt = 1'b0;
		ctl.noOp = 1'b0;
		ctl.illegal = 1'b0;

		case (op)
			5'b00000: ctl.halt = 1'b1;
			5'b00001: ctl.noOp = 1'b1;
			// j and jal, target from the PC adder
			5'b00100, 5'b00110: begin
				ctl.jump = 1'b1;
				ctl.aluSrc = 1'b1;
				ctl.regWrite = op[1];
				ctl.link = op[1];
			end
			// jr and jalr, target is rs plus immediate
			5'b00101, 5'b00111: begin
				ctl.jump = 1'b1;
				ctl.aluSrc = 1'b1;
				ctl.regWrite = op[1];
				ctl.link = op[1];
				ctl.aluOp = aluAdd;
			end
			// addi subi xori andni
			5'b01000, 5'b01001, 5'b01010, 5'b01011: begin
				ctl.regWrite = 1'b1;
				ctl.aluSrc = 1'b1;
				ctl.aluOp = pickOp(1'b0, op[1:0]);
			end
			// Branch on rs against zero
			5'b01100, 5'b01101, 5'b01110, 5'b01111: begin
				ctl.branch = 1'b1;
				ctl.aluSrc = 1'b1;
				case (op[1:0])
					2'b00: ctl.aluOp = aluEqz;
					2'b01: ctl.aluOp = aluNez;
					2'b10: ctl.aluOp = aluLtz;
					default: ctl.aluOp = aluGez;
				endcase
			end
			5'b10000: begin
				ctl.aluSrc = 1'b1;
				ctl.memWrite = 1'b1;
				ctl.memToReg = 1'b1;
				ctl.aluOp = aluAdd;
			end
			5'b10001: begin
				ctl.regWrite = 1'b1;
				ctl.aluSrc = 1'b1;
				ctl.memRead = 1'b1;
				ctl.memToReg = 1'b1;
				ctl.aluOp = aluAdd;
			end
			5'b10010: begin
				ctl.regWrite = 1'b1;
				ctl.aluSrc = 1'b1;
				ctl.aluOp = aluSlbi;
			end
			// stu writes the updated address back to rs
			5'b10011: begin
				ctl.regWrite = 1'b1;
				ctl.aluSrc = 1'b1;
				ctl.memWrite = 1'b1;
				ctl.memToReg = 1'b1;
				ctl.stu = 1'b1;
				ctl.aluOp = aluAdd;
			end
			5'b10100, 5'b10101, 5'b10110, 5'b10111: begin
				ctl.regWrite = 1'b1;
				ctl.aluSrc = 1'b1;
				ctl.aluOp = pickOp(1'b1, op[1:0]);
			end
			5'b11000: begin
				ctl.regWrite = 1'b1;
				ctl.aluSrc = 1'b1;
				ctl.aluOp = aluLbi;
			end
			5'b11001: begin
				ctl.regWrite = 1'b1;
				ctl.aluOp = aluBtr;
			end
			// R format, function bits pick the operation
			5'b11010, 5'b11011: begin
				ctl.regWrite = 1'b1;
				ctl.aluOp = pickOp(~op[0], func);
			end
			5'b11100, 5'b11101, 5'b11110, 5'b11111: begin
				ctl.regWrite = 1'b1;
				ctl.aluOp = aluOpT'(5'd8 + {3'b000, op[1:0]});
			end
			// siic and rti are not supported
			default: ctl.illegal = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

//--- operandDecoder.sv
// Register field and immediate extraction
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module operandDecoder import isaPkg::*; (
	input instrT instr,
	opndIf.source opnd
);

	localparam regIdxT LinkReg = regIdxT'(`REG_COUNT - 1);

	opcodeT op;
	formatT fmt;
	logic zeroExt;

	assign op = instr[15:11];

	// First match wins, slbi sits inside the 100?? memory block
	always_comb begin
		casez (op)
			5'b00100, 5'b00110: fmt = fmtJ;
			5'b10010, 5'b11000, 5'b011??, 5'b00101, 5'b00111: fmt = fmtI2;
			5'b010??, 5'b100??, 5'b101??: fmt = fmtI1;
			default: fmt = fmtR;
		endcase
	end

	// xori, andni and slbi take unsigned immediates
	assign zeroExt = (op == 5'b01010) || (op == 5'b01011) || (op == 5'b10010);

	assign opnd.rs = instr[10:8];
	assign opnd.rt = instr[7:5];

	always_comb begin
		case (fmt)
			fmtR: opnd.rd = instr[4:2];
			fmtI1: opnd.rd = instr[7:5];
			default: opnd.rd = instr[10:8];
		endcase
		// jal and jalr
		if (op[4:1] == 4'b0011) begin
			opnd.rd = LinkReg;
		end
	end

	always_comb begin
		case (fmt)
			fmtI1: begin
				opnd.imm = {{(`DATA_WIDTH-5){instr[4] & ~zeroExt}}, instr[4:0]};
			end
			fmtI2: begin
				opnd.imm = {{(`DATA_WIDTH-8){instr[7] & ~zeroExt}}, instr[7:0]};
			end
			fmtJ: begin
				opnd.imm = {{(`DATA_WIDTH-11){instr[10]}}, instr[10:0]};
			end
			default: opnd.imm = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- decodeRegister.sv
// Registered decode word
`timescale 1ns/1ps
`default_nettype none

module decodeRegister import isaPkg::*, ctlPkg::*; (
	input logic clk,
	input logic arstN,
	input logic instrValid,
	input logic stall,
	ctlIf.sink ctl,
	opndIf.sink opnd,
	output logic outValid,
	output logic regWrite,
	output logic aluSrc,
	output logic memWrite,
	output logic memRead,
	output logic memToReg,
	output logic branch,
	output logic jump,
	output logic link,
	output logic stu,
	output logic illegal,
	output logic halted,
	output aluOpT aluOp,
	output regIdxT rs,
	output regIdxT rt,
	output regIdxT rd,
	output wordT imm
);

	decStateT state;
	decStateT nextState;
	logic accept;
	logic writeOk;

	// Nothing is taken once halted
	assign accept = instrValid && !stall && (state == stRun);
	assign writeOk = accept && !ctl.illegal && !ctl.noOp;
	assign halted = (state == stHalted);

	always_comb begin
		nextState = state;
		case (state)
			stRun: if (accept && ctl.halt) nextState = stHalted;
			stHalted: nextState = stHalted;
			default: nextState = stRun;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= stRun;
			outValid <= 1'b0;
			regWrite <= 1'b0;
			memWrite <= 1'b0;
			memRead <= 1'b0;
			branch <= 1'b0;
			jump <= 1'b0;
			illegal <= 1'b0;
		end else if (!stall) begin
			state <= nextState;
			outValid <= accept;
			regWrite <= writeOk && ctl.regWrite;
			memWrite <= writeOk && ctl.memWrite;
			memRead <= accept && ctl.memRead;
			branch <= accept && ctl.branch;
			jump <= accept && ctl.jump;
			illegal <= accept && ctl.illegal;
		end
	end

	// Operand and qualifier fields follow the decoders
	always_ff @(posedge clk) begin
		if (!stall) begin
			aluSrc <= ctl.aluSrc;
			memToReg <= ctl.memToReg;
			link <= ctl.link;
			stu <= ctl.stu;
			aluOp <= ctl.aluOp;
			rs <= opnd.rs;
			rt <= opnd.rt;
			rd <= opnd.rd;
			imm <= opnd.imm;
		end
	end

endmodule

`default_nettype wire

//--- decodeStage.sv
// Instruction decode stage
`timescale 1ns/1ps
`default_nettype none

module decodeStage import isaPkg::*, ctlPkg::*; (
	input logic clk,
	input logic arstN,
	input instrT instr,
	input logic instrValid,
	input logic stall,
	output logic outValid,
	output logic regWrite,
	output logic aluSrc,
	output logic memWrite,
	output logic memRead,
	output logic memToReg,
	output logic branch,
	output logic jump,
	output logic link,
	output logic stu,
	output logic illegal,
	output logic halted,
	output aluOpT aluOp,
	output regIdxT rs,
	output regIdxT rt,
	output regIdxT rd,
	output wordT imm
);

	ctlIf ctlBus ();
	opndIf opndBus ();

	// Both decoders see the same instruction
	controlDecoder ctlDec0 (
		.instr(instr),
		.ctl(ctlBus.source)
	);

	operandDecoder opndDec0 (
		.instr(instr),
		.opnd(opndBus.source)
	);

	decodeRegister decReg0 (
		.clk(clk),
		.arstN(arstN),
		.instrValid(instrValid),
		.stall(stall),
		.ctl(ctlBus.sink),
		.opnd(opndBus.sink),
		.outValid(outValid),
		.regWrite(regWrite),
		.aluSrc(aluSrc),
		.memWrite(memWrite),
		.memRead(memRead),
		.memToReg(memToReg),
		.branch(branch),
		.jump(jump),
		.link(link),
		.stu(stu),
		.illegal(illegal),
		.halted(halted),
		.aluOp(aluOp),
		.rs(rs),
		.rt(rt),
		.rd(rd),
		.imm(imm)
	);

endmodule

`default_nettype wire

//--- tbClock.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tbClock (
	output logic clk,
	output logic arstN
);

	// 10 ns period
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Reset held low for eight rising edges
	initial begin
		arstN = 1'b0;
		repeat (8) @(posedge clk);
		arstN <= 1'b1;
	end

endmodule

`default_nettype wire

//--- decodeStageTb.sv
// Decode stage testbench
`timescale 1ns/1ps
`default_nettype none

module decodeStageTb import isaPkg::*, ctlPkg::*; ();

	localparam int Fields = 20;
	localparam int MaxVec = 64;
	localparam int ResetCycles = 8;

	logic clk;
	logic arstN;
	instrT instr;
	logic instrValid;
	logic stall;
	logic outValid, regWrite, aluSrc, memWrite, memRead, memToReg;
	logic branch, jump, link, stu, illegal, halted;
	aluOpT aluOp;
	regIdxT rs, rt, rd;
	wordT imm;

	logic [15:0] vecMem [0:MaxVec*Fields-1];
	int numVec;
	int curVec;
	int valueErrors;
	int otherErrors;
	int stimFd;
	int cycles = 0;
	int limit;
	logic limitReady = 1'b0;

	tbClock clkGen0 (
		.clk(clk),
		.arstN(arstN)
	);

	decodeStage dut0 (.*);

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail %s vector %0d got %h expected %h", name, curVec, got, exp);
			valueErrors++;
		end
	endtask

	task automatic checkAluOp(input string name, input aluOpT got, input aluOpT exp);
		if (got !== exp) begin
			$display("Fail %s vector %0d got %h expected %h", name, curVec, got, exp);
			valueErrors++;
		end
	endtask

	task automatic checkReg(input string name, input regIdxT got, input regIdxT exp);
		if (got !== exp) begin
			$display("Fail %s vector %0d got %h expected %h", name, curVec, got, exp);
			valueErrors++;
		end
	endtask

	task automatic checkWord(input string name, input wordT got, input wordT exp);
		if (got !== exp) begin
			$display("Fail %s vector %0d got %h expected %h", name, curVec, got, exp);
			valueErrors++;
		end
	endtask

	task automatic applyVector(input int v);
		instr <= vecMem[v*Fields];
		instrValid <= vecMem[v*Fields+1][0];
		stall <= vecMem[v*Fields+2][0];
	endtask

	// Columns 3 to 19 hold the registered outputs
	task automatic checkVector(input int v);
		int b;
		b = v * Fields;
		curVec = v;
		checkBit("outValid", outValid, vecMem[b+3][0]);
		checkBit("regWrite", regWrite, vecMem[b+4][0]);
		checkBit("aluSrc", aluSrc, vecMem[b+5][0]);
		checkBit("memWrite", memWrite, vecMem[b+6][0]);
		checkBit("memRead", memRead, vecMem[b+7][0]);
		checkBit("memToReg", memToReg, vecMem[b+8][0]);
		checkBit("branch", branch, vecMem[b+9][0]);
		checkBit("jump", jump, vecMem[b+10][0]);
		checkBit("link", link, vecMem[b+11][0]);
		checkBit("stu", stu, vecMem[b+12][0]);
		checkAluOp("aluOp", aluOp, aluOpT'(vecMem[b+13][4:0]));
		checkReg("rs", rs, regIdxT'(vecMem[b+14][2:0]));
		checkReg("rt", rt, regIdxT'(vecMem[b+15][2:0]));
		checkReg("rd", rd, regIdxT'(vecMem[b+16][2:0]));
		checkWord("imm", imm, vecMem[b+17]);
		checkBit("halted", halted, vecMem[b+18][0]);
		checkBit("illegal", illegal, vecMem[b+19][0]);
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limitReady && cycles >= limit) begin
			$display("Timeout after %0d cycles, the vector loop never finished", cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	initial begin
		instr = 16'h0800;
		instrValid = 1'b0;
		stall = 1'b0;
		valueErrors = 0;
		otherErrors = 0;
		numVec = 0;
		curVec = 0;
		// Valid column of an unloaded vector never reads as 0 or 1
		for (int i = 0; i < MaxVec * Fields; i++) begin
			vecMem[i] = 16'hF000 | 16'(i);
		end
		stimFd = $fopen("decode_stimulus.txt", "r");
		if (stimFd == 0) begin
			$display("Could not open decode_stimulus.txt for reading");
			otherErrors++;
		end else begin
			$fclose(stimFd);
			$readmemh("decode_stimulus.txt", vecMem);
			while (numVec < MaxVec && vecMem[numVec*Fields+1] <= 16'h0001) begin
				numVec++;
			end
			if (numVec == 0) begin
				$display("No vectors could be read from decode_stimulus.txt");
				otherErrors++;
			end
		end
		limit = numVec + ResetCycles + 20;
		limitReady = 1'b1;

		wait (arstN === 1'b1);
		// Drive vector k and check vector k-1 from the same edge
		for (int k = 0; k <= numVec; k++) begin
			@(posedge clk);
			if (k < numVec) begin
				applyVector(k);
			end
			@(negedge clk);
			if (k > 0) begin
				checkVector(k - 1);
			end
		end

		$display("Errors: %0d value mismatches, %0d other", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- decode_stimulus.txt
// instr instrValid stall | outValid regWrite aluSrc memWrite memRead memToReg branch jump link stu
// aluOp rs rt rd imm halted illegal, one vector per line, all hex
D94C 1 0 1 1 0 0 0 0 0 0 0 0 00 1 2 3 0000 0 0
DA71 1 0 1 1 0 0 0 0 0 0 0 0 01 2 3 4 0000 0 0
DB96 1 0 1 1 0 0 0 0 0 0 0 0 02 3 4 5 0000 0 0
DCBB 1 0 1 1 0 0 0 0 0 0 0 0 03 4 5 6 0000 0 0
D5DC 1 0 1 1 0 0 0 0 0 0 0 0 04 5 6 7 0000 0 0
D6E1 1 0 1 1 0 0 0 0 0 0 0 0 05 6 7 0 0000 0 0
D706 1 0 1 1 0 0 0 0 0 0 0 0 06 7 0 1 0000 0 0
D02B 1 0 1 1 0 0 0 0 0 0 0 0 07 0 1 2 0000 0 0
E14C 1 0 1 1 0 0 0 0 0 0 0 0 08 1 2 3 0000 0 0
C908 1 0 1 1 0 0 0 0 0 0 0 0 0C 1 0 2 0000 0 0
4150 1 0 1 1 1 0 0 0 0 0 0 0 00 1 2 2 FFF0 0 0
539F 1 0 1 1 1 0 0 0 0 0 0 0 02 3 4 4 001F 0 0
8158 1 0 1 0 1 1 0 1 0 0 0 0 00 1 2 2 FFF8 0 0
8B87 1 0 1 1 1 0 1 1 0 0 0 0 00 3 4 4 0007 0 0
9DD1 1 0 1 1 1 1 0 1 0 0 0 1 00 5 6 6 FFF1 0 0
92F0 1 0 1 1 1 0 0 0 0 0 0 0 0E 2 7 2 00F0 0 0
C480 1 0 1 1 1 0 0 0 0 0 0 0 0D 4 4 4 FF80 0 0
A143 1 0 1 1 1 0 0 0 0 0 0 0 04 1 2 2 0003 0 0
6385 1 0 1 0 1 0 0 0 1 0 0 0 0F 3 4 3 FF85 0 0
7E12 1 0 1 0 1 0 0 0 1 0 0 0 12 6 0 6 0012 0 0
2400 1 0 1 0 1 0 0 0 0 1 0 0 13 4 0 4 FC00 0 0
3123 1 0 1 1 1 0 0 0 0 1 1 0 13 1 1 7 0123 0 0
3AFE 1 0 1 1 1 0 0 0 0 1 1 0 00 2 7 7 FFFE 0 0
2D04 1 0 1 0 1 0 0 0 0 1 0 0 00 5 0 5 0004 0 0
D94C 1 1 1 0 1 0 0 0 0 1 0 0 00 5 0 5 0004 0 0
8B87 0 0 0 0 1 0 0 1 0 0 0 0 00 3 4 4 0007 0 0
0800 1 0 1 0 0 0 0 0 0 0 0 0 13 0 0 0 0000 0 0
114C 1 0 1 0 0 0 0 0 0 0 0 0 13 1 2 3 0000 0 1
1800 1 0 1 0 0 0 0 0 0 0 0 0 13 0 0 0 0000 0 1
0000 1 0 1 0 0 0 0 0 0 0 0 0 13 0 0 0 0000 1 0
4150 1 0 0 0 1 0 0 0 0 0 0 0 00 1 2 2 FFF0 1 0
114C 1 0 0 0 0 0 0 0 0 0 0 0 13 1 2 3 0000 1 0

//--- project.f
+incdir+.
isaPkg.sv
ctlPkg.sv
ctlIf.sv
opndIf.sv
controlDecoder.sv
operandDecoder.sv
decodeRegister.sv
decodeStage.sv
tbClock.sv
decodeStageTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module decodeStageTb -o decodeSim
simOut=$(./obj_dir/decodeSim)
echo "$simOut"

if grep -qx "TB PASSED" <<< "$simOut"; then
	exit 0
fi
exit 1
